/* gemm_cfg_pkg.sv */
package gemm_cfg_pkg;

  // first address of the accelerator csr window
  localparam int unsigned CsrBase = 32'h3c0;

  // ----------------------------------------
  // csr offsets from CsrBase
  // ----------------------------------------
  // k in bits 7..0
  localparam int unsigned SizeCsr    = 0;
  localparam int unsigned AddrACsr   = 1;
  localparam int unsigned AddrBCsr   = 2;
  localparam int unsigned AddrCCsr   = 3;
  localparam int unsigned StrideACsr = 4;
  localparam int unsigned StrideBCsr = 5;
  // busy cycle count, read only
  localparam int unsigned PerfCsr    = 6;
  // bit 0 start on write, busy on read; bit 1 idle
  localparam int unsigned StateCsr   = 7;
  localparam int unsigned CsrNum     = 8;

  typedef logic [2:0] csr_idx_t;

  typedef struct packed {
    logic [7:0]  k;
    logic [31:0] ptr_a;
    logic [31:0] ptr_b;
    logic [31:0] ptr_c;
    logic [31:0] stride_a;
    logic [31:0] stride_b;
  } gemm_cfg_t;

  typedef struct packed {
    logic [31:0] data;
    logic [31:0] addr;
    logic        read;
    logic [4:0]  id;
  } csr_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [4:0]  id;
  } csr_rsp_t;

endpackage

/* tcdm_pkg.sv */
package tcdm_pkg;

  // A0, A1, B0, B1
  localparam int unsigned ReadPorts  = 4;
  // C00, C01, C10, C11
  localparam int unsigned WritePorts = 4;

  // ----------------------------------------
  // one memory port
  // ----------------------------------------
  typedef struct packed {
    logic        q_valid;
    logic [31:0] addr;
    logic        write;
    logic [31:0] data;
    logic [3:0]  strb;
  } tcdm_req_t;

  // q_ready grants the request, p_valid returns read data later
  typedef struct packed {
    logic        q_ready;
    logic        p_valid;
    logic [31:0] data;
  } tcdm_rsp_t;

endpackage

/* gemm_csr.sv */
`timescale 1ns/1ps

module gemm_csr (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    csr_qvalid_i,
  input  gemm_cfg_pkg::csr_req_t  csr_req_i,
  output logic                    csr_qready_o,
  output gemm_cfg_pkg::csr_rsp_t  csr_rsp_o,
  output logic                    csr_pvalid_o,
  input  logic                    busy_i,
  output logic                    start_o,
  output gemm_cfg_pkg::gemm_cfg_t cfg_o
);

  logic [31:0]            csr_q [gemm_cfg_pkg::CsrNum];
  logic [31:0]            csr_off;
  gemm_cfg_pkg::csr_idx_t csr_idx;
  logic                   csr_hit;
  logic                   csr_wr;
  logic                   state_sel;
  logic                   idle_q;
  logic [31:0]            perf_q;
  logic [31:0]            rd_data;

  assign csr_off = csr_req_i.addr - gemm_cfg_pkg::CsrBase;
  assign csr_idx = csr_off[2:0];
  assign csr_hit = csr_off < gemm_cfg_pkg::CsrNum;

  // a state write while busy is held off until the tile is done
  assign state_sel    = csr_qvalid_i && !csr_req_i.read && csr_hit &&
                        (csr_idx == gemm_cfg_pkg::StateCsr);
  assign csr_qready_o = !(state_sel && !idle_q);
  assign csr_wr       = csr_qvalid_i && csr_qready_o && !csr_req_i.read && csr_hit;
  assign start_o      = state_sel && idle_q && csr_req_i.data[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < gemm_cfg_pkg::CsrNum; i++) begin
        csr_q[i] <= '0;
      end
    end else if (csr_wr && (csr_idx != gemm_cfg_pkg::StateCsr) &&
                 (csr_idx != gemm_cfg_pkg::PerfCsr)) begin
      csr_q[csr_idx] <= csr_req_i.data;
    end
  end

  // ----------------------------------------
  // state and performance counter
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_q <= 1'b1;
      perf_q <= '0;
    end else if (start_o) begin
      idle_q <= 1'b0;
      perf_q <= '0;
    end else begin
      idle_q <= !busy_i;
      if (busy_i) begin
        perf_q <= perf_q + 32'd1;
      end
    end
  end

  // reads are answered in the same cycle
  always_comb begin
    case (csr_idx)
      gemm_cfg_pkg::PerfCsr:  rd_data = perf_q;
      gemm_cfg_pkg::StateCsr: rd_data = {30'b0, idle_q, !idle_q};
      default:                rd_data = csr_q[csr_idx];
    endcase
  end

  assign csr_pvalid_o   = csr_qvalid_i && csr_req_i.read;
  assign csr_rsp_o.data = csr_hit ? rd_data : '0;
  assign csr_rsp_o.id   = csr_req_i.id;

  assign cfg_o.k        = csr_q[gemm_cfg_pkg::SizeCsr][7:0];
  assign cfg_o.ptr_a    = csr_q[gemm_cfg_pkg::AddrACsr];
  assign cfg_o.ptr_b    = csr_q[gemm_cfg_pkg::AddrBCsr];
  assign cfg_o.ptr_c    = csr_q[gemm_cfg_pkg::AddrCCsr];
  assign cfg_o.stride_a = csr_q[gemm_cfg_pkg::StrideACsr];
  assign cfg_o.stride_b = csr_q[gemm_cfg_pkg::StrideBCsr];

endmodule

/* gemm_ctrl.sv */
`timescale 1ns/1ps

module gemm_ctrl (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       start_i,
  input  logic [7:0] k_total_i,
  input  logic       rd_granted_all_i,
  input  logic       data_ready_i,
  input  logic       wr_granted_all_i,
  output logic       read_en_o,
  output logic       acc_en_o,
  output logic       clear_o,
  output logic       write_en_o,
  output logic       busy_o,
  output logic [7:0] k_idx_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRead,
    StAcc,
    StWrite
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic [7:0] k_q;
  logic [7:0] k_d;
  logic       last_step;

  assign last_step = (k_q + 8'd1) == k_total_i;

  always_comb begin
    state_d = state_q;
    k_d     = k_q;
    case (state_q)
      StIdle: begin
        if (start_i) begin
          k_d = '0;
          // an empty K still writes out the cleared tile
          state_d = (k_total_i == 8'd0) ? StWrite : StRead;
        end
      end
      StRead: begin
        if (rd_granted_all_i) begin
          state_d = StAcc;
        end
      end
      StAcc: begin
        if (data_ready_i) begin
          k_d     = k_q + 8'd1;
          state_d = last_step ? StWrite : StRead;
        end
      end
      StWrite: begin
        if (wr_granted_all_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      k_q     <= '0;
    end else begin
      state_q <= state_d;
      k_q     <= k_d;
    end
  end

  assign read_en_o  = state_q == StRead;
  assign acc_en_o   = (state_q == StAcc) && data_ready_i;
  assign clear_o    = (state_q == StIdle) && start_i;
  assign write_en_o = state_q == StWrite;
  assign busy_o     = state_q != StIdle;
  assign k_idx_o    = k_q;

endmodule

/* tcdm_req_gen.sv */
`timescale 1ns/1ps

module tcdm_req_gen #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  gemm_cfg_pkg::gemm_cfg_t                       cfg_i,
  input  logic [7:0]                                    k_idx_i,
  input  logic                                          read_en_i,
  input  logic                                          write_en_i,
  input  logic [tcdm_pkg::WritePorts-1:0][DataWidth-1:0] result_i,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] rsp_i,
  output tcdm_pkg::tcdm_req_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] req_o,
  output logic                                          rd_granted_all_o,
  output logic                                          wr_granted_all_o
);

  localparam int unsigned RdPorts  = tcdm_pkg::ReadPorts;
  localparam int unsigned WrPorts  = tcdm_pkg::WritePorts;
  // first half of the read ports fetch A rows, second half B columns
  localparam int unsigned RowPorts = RdPorts / 2;

  logic [AddrWidth-1:0] a_base;
  logic [AddrWidth-1:0] b_base;
  logic [RdPorts-1:0]   rd_mask_q;
  logic [RdPorts-1:0]   rd_done;
  logic [WrPorts-1:0]   wr_mask_q;
  logic [WrPorts-1:0]   wr_done;

  assign a_base = cfg_i.ptr_a[AddrWidth-1:0] +
                  AddrWidth'(k_idx_i) * cfg_i.stride_a[AddrWidth-1:0];
  assign b_base = cfg_i.ptr_b[AddrWidth-1:0] +
                  AddrWidth'(k_idx_i) * cfg_i.stride_b[AddrWidth-1:0];

  // a granted port stays quiet until its whole phase is granted
  always_comb begin
    for (int i = 0; i < RdPorts; i++) begin
      req_o[i].q_valid = read_en_i && !rd_mask_q[i];
      req_o[i].addr    = ((i < RowPorts) ? a_base : b_base) + AddrWidth'(4 * (i % RowPorts));
      req_o[i].write   = 1'b0;
      req_o[i].data    = '0;
      req_o[i].strb    = '0;
      rd_done[i]       = rd_mask_q[i] || (req_o[i].q_valid && rsp_i[i].q_ready);
    end
    for (int j = 0; j < WrPorts; j++) begin
      req_o[RdPorts+j].q_valid = write_en_i && !wr_mask_q[j];
      req_o[RdPorts+j].addr    = cfg_i.ptr_c[AddrWidth-1:0] + AddrWidth'(4 * j);
      req_o[RdPorts+j].write   = 1'b1;
      req_o[RdPorts+j].data    = result_i[j];
      req_o[RdPorts+j].strb    = '1;
      wr_done[j] = wr_mask_q[j] || (req_o[RdPorts+j].q_valid && rsp_i[RdPorts+j].q_ready);
    end
  end

  assign rd_granted_all_o = &rd_done;
  assign wr_granted_all_o = &wr_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_mask_q <= '0;
      wr_mask_q <= '0;
    end else begin
      rd_mask_q <= (rd_granted_all_o || !read_en_i) ? '0 : rd_done;
      wr_mask_q <= (wr_granted_all_o || !write_en_i) ? '0 : wr_done;
    end
  end

endmodule

/* tcdm_rsp_collect.sv */
`timescale 1ns/1ps

module tcdm_rsp_collect #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         read_en_i,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::ReadPorts-1:0] rsp_i,
  output logic [tcdm_pkg::ReadPorts-1:0][DataWidth-1:0] data_o,
  output logic                                         data_ready_o
);

  logic [tcdm_pkg::ReadPorts-1:0]                valid_q;
  logic [tcdm_pkg::ReadPorts-1:0]                valid_now;
  logic [tcdm_pkg::ReadPorts-1:0][DataWidth-1:0] data_q;

  // a port counts as answered if it answered earlier or answers now
  always_comb begin
    for (int i = 0; i < tcdm_pkg::ReadPorts; i++) begin
      valid_now[i] = valid_q[i] || rsp_i[i].p_valid;
      data_o[i]    = rsp_i[i].p_valid ? rsp_i[i].data : data_q[i];
    end
  end

  // hand over only once no request of the step is left outstanding
  assign data_ready_o = (&valid_now) && !read_en_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (data_ready_o) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_now;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < tcdm_pkg::ReadPorts; i++) begin
      if (rsp_i[i].p_valid) begin
        data_q[i] <= rsp_i[i].data;
      end
    end
  end

endmodule

/* gemm_mac_array.sv */
`timescale 1ns/1ps

module gemm_mac_array #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      acc_en_i,
  input  logic [1:0][DataWidth-1:0] a_i,
  input  logic [1:0][DataWidth-1:0] b_i,
  output logic [3:0][DataWidth-1:0] result_o
);

  localparam int unsigned Lanes = DataWidth / 8;

  logic [3:0][DataWidth-1:0] acc_q;

  // signed 8-bit dot product over all lanes of one word
  function automatic logic [DataWidth-1:0] dot(input logic [DataWidth-1:0] a,
                                               input logic [DataWidth-1:0] b);
    logic signed [DataWidth-1:0] sum;
    sum = '0;
    for (int i = 0; i < Lanes; i++) begin
      sum = sum + $signed(a[8*i +: 8]) * $signed(b[8*i +: 8]);
    end
    return sum;
  endfunction

  // element (r,c) sits at index 2r+c
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      for (int r = 0; r < 2; r++) begin
        for (int c = 0; c < 2; c++) begin
          acc_q[2*r+c] <= acc_q[2*r+c] + dot(a_i[r], b_i[c]);
        end
      end
    end
  end

  assign result_o = acc_q;

endmodule

/* snax_gemm_top.sv */
`timescale 1ns/1ps

module snax_gemm_top #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned AddrWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   csr_qvalid_i,
  input  gemm_cfg_pkg::csr_req_t csr_req_i,
  output logic                   csr_qready_o,
  output gemm_cfg_pkg::csr_rsp_t csr_rsp_o,
  output logic                   csr_pvalid_o,
  // responses are never stalled, so pready is not looked at
  input  logic                   csr_pready_i,
  output tcdm_pkg::tcdm_req_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] tcdm_req_o,
  input  tcdm_pkg::tcdm_rsp_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] tcdm_rsp_i
);

  gemm_cfg_pkg::gemm_cfg_t                        cfg;
  logic                                           start;
  logic                                           busy;
  logic                                           read_en;
  logic                                           acc_en;
  logic                                           clear;
  logic                                           write_en;
  logic [7:0]                                     k_idx;
  logic                                           rd_granted_all;
  logic                                           wr_granted_all;
  logic                                           data_ready;
  logic [tcdm_pkg::ReadPorts-1:0][DataWidth-1:0]  rd_data;
  logic [tcdm_pkg::WritePorts-1:0][DataWidth-1:0] result;

  gemm_csr gemm_csr_i (
    .clk_i, .rst_ni, .csr_qvalid_i, .csr_req_i, .csr_qready_o, .csr_rsp_o, .csr_pvalid_o,
    .busy_i(busy), .start_o(start), .cfg_o(cfg)
  );

  gemm_ctrl gemm_ctrl_i (
    .clk_i, .rst_ni, .start_i(start), .k_total_i(cfg.k),
    .rd_granted_all_i(rd_granted_all), .data_ready_i(data_ready),
    .wr_granted_all_i(wr_granted_all), .read_en_o(read_en), .acc_en_o(acc_en),
    .clear_o(clear), .write_en_o(write_en), .busy_o(busy), .k_idx_o(k_idx)
  );

  tcdm_req_gen #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) tcdm_req_gen_i (
    .clk_i, .rst_ni, .cfg_i(cfg), .k_idx_i(k_idx), .read_en_i(read_en),
    .write_en_i(write_en), .result_i(result), .rsp_i(tcdm_rsp_i), .req_o(tcdm_req_o),
    .rd_granted_all_o(rd_granted_all), .wr_granted_all_o(wr_granted_all)
  );

  tcdm_rsp_collect #(.DataWidth(DataWidth)) tcdm_rsp_collect_i (
    .clk_i, .rst_ni, .read_en_i(read_en), .rsp_i(tcdm_rsp_i[tcdm_pkg::ReadPorts-1:0]),
    .data_o(rd_data), .data_ready_o(data_ready)
  );

  // read ports 0..1 carry A rows, 2..3 carry B columns
  gemm_mac_array #(.DataWidth(DataWidth)) gemm_mac_array_i (
    .clk_i, .rst_ni, .clear_i(clear), .acc_en_i(acc_en),
    .a_i(rd_data[1:0]), .b_i(rd_data[3:2]), .result_o(result)
  );

endmodule

/* tb_snax_gemm_chk.sv */
`timescale 1ns/1ps

module tb_snax_gemm_chk (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   csr_qvalid_i,
  input gemm_cfg_pkg::csr_req_t csr_req_i,
  input logic                   csr_qready_o,
  input logic                   csr_pvalid_o,
  input tcdm_pkg::tcdm_req_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] tcdm_req_o,
  input tcdm_pkg::tcdm_rsp_t [tcdm_pkg::ReadPorts+tcdm_pkg::WritePorts-1:0] tcdm_rsp_i
);

  // csr reads are accepted and answered in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_qvalid_i && csr_req_i.read |-> csr_pvalid_o && csr_qready_o)
    else $error("csr read not answered in its request cycle");

  assert property (@(posedge clk_i) disable iff (!rst_ni) csr_pvalid_o |-> csr_qvalid_i)
    else $error("csr response without a request");

  // ----------------------------------------
  // memory ports
  // ----------------------------------------
  for (genvar p = 0; p < tcdm_pkg::ReadPorts + tcdm_pkg::WritePorts; p++) begin : g_port
    // a stalled request keeps valid and payload
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      tcdm_req_o[p].q_valid && !tcdm_rsp_i[p].q_ready |=>
      tcdm_req_o[p].q_valid && $stable(tcdm_req_o[p]))
      else $error("memory request on port %0d dropped or changed while stalled", p);

    assert property (@(posedge clk_i) !rst_ni |-> !tcdm_req_o[p].q_valid)
      else $error("memory request on port %0d during reset", p);
  end

endmodule

/* tb_snax_gemm.sv */
`timescale 1ns/1ps

module tb_snax_gemm;

  localparam int Ports    = tcdm_pkg::ReadPorts + tcdm_pkg::WritePorts;
  localparam int DriveDly = 10;
  localparam int Timeout  = 200;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            csr_qvalid_i;
  gemm_cfg_pkg::csr_req_t          csr_req_i;
  logic                            csr_qready_o;
  gemm_cfg_pkg::csr_rsp_t          csr_rsp_o;
  logic                            csr_pvalid_o;
  logic                            csr_pready_i;
  tcdm_pkg::tcdm_req_t [Ports-1:0] tcdm_req_o;
  tcdm_pkg::tcdm_rsp_t [Ports-1:0] tcdm_rsp_i;

  logic [31:0] stim [256];
  logic [31:0] mem [1024];
  int          pend [Ports];
  logic [31:0] pend_addr [Ports];
  logic        backpressure = 1'b0;
  int          seed = 18344;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;

  snax_gemm_top #(.DataWidth(32), .AddrWidth(32)) snax_gemm_top_i (.*);

  bind snax_gemm_top tb_snax_gemm_chk tb_snax_gemm_chk_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** FAILED ***");
    $finish;
  endtask

  // one csr transfer, started a drive delay after a rising edge
  task automatic csr_access(input int idx, input logic rd, input logic [31:0] wdata,
                            input logic [4:0] id, output logic [31:0] rdata);
    int n;
    n = 0;
    csr_qvalid_i   = 1'b1;
    csr_req_i.addr = gemm_cfg_pkg::CsrBase + idx;
    csr_req_i.read = rd;
    csr_req_i.data = wdata;
    csr_req_i.id   = id;
    @(negedge clk_i);
    while (!csr_qready_o) begin
      n++;
      if (n > Timeout) abort_on_timeout("csr_qready_o");
      @(negedge clk_i);
    end
    rdata = csr_rsp_o.data;
    if (rd) begin
      compare("csr_pvalid_o", 32'(csr_pvalid_o), 32'd1);
      compare("csr_rsp_o.id", 32'(csr_rsp_o.id), 32'(id));
    end
    @(posedge clk_i);
    #DriveDly;
    csr_qvalid_i = 1'b0;
  endtask

  // offers a write for one cycle and checks whether it is taken
  task automatic probe_write_ready(input int idx, input logic [31:0] wdata, input logic ready);
    csr_qvalid_i   = 1'b1;
    csr_req_i.addr = gemm_cfg_pkg::CsrBase + idx;
    csr_req_i.read = 1'b0;
    csr_req_i.data = wdata;
    csr_req_i.id   = 5'd0;
    @(negedge clk_i);
    compare("csr_qready_o", 32'(csr_qready_o), 32'(ready));
    @(posedge clk_i);
    #DriveDly;
    csr_qvalid_i = 1'b0;
  endtask

  function automatic logic [31:0] signed_byte_dot(input logic [31:0] a, input logic [31:0] b);
    int                sum;
    logic signed [7:0] x;
    logic signed [7:0] y;
    sum = 0;
    for (int l = 0; l < 4; l++) begin
      x = a[8*l +: 8];
      y = b[8*l +: 8];
      sum = sum + int'(x) * int'(y);
    end
    return sum;
  endfunction

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin
    logic [31:0] rnd;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'(i) ^ 32'ha5a50000;
    end
    for (int p = 0; p < Ports; p++) begin
      pend[p] = 0;
    end
    tcdm_rsp_i = '0;
    forever begin
      // grants are taken at the next rising edge
      @(negedge clk_i);
      for (int p = 0; p < Ports; p++) begin
        if (tcdm_req_o[p].q_valid && tcdm_rsp_i[p].q_ready) begin
          if (tcdm_req_o[p].write) begin
            // only the enabled bytes are written
            for (int b = 0; b < 4; b++) begin
              if (tcdm_req_o[p].strb[b]) begin
                mem[tcdm_req_o[p].addr[11:2]][8*b +: 8] = tcdm_req_o[p].data[8*b +: 8];
              end
            end
          end else begin
            rnd = $random(seed);
            pend[p]      = backpressure ? 1 + int'(rnd % 3) : 1;
            pend_addr[p] = tcdm_req_o[p].addr;
          end
        end
      end
      @(posedge clk_i);
      #DriveDly;
      for (int p = 0; p < Ports; p++) begin
        rnd = $random(seed);
        tcdm_rsp_i[p].q_ready = backpressure ? rnd[0] : 1'b1;
        tcdm_rsp_i[p].p_valid = 1'b0;
        if (pend[p] > 0) begin
          pend[p]--;
          if (pend[p] == 0) begin
            tcdm_rsp_i[p].p_valid = 1'b1;
            tcdm_rsp_i[p].data    = mem[pend_addr[p][11:2]];
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [31:0] cfg [6];
    logic [31:0] exp_c [4];
    int          ntests;
    int          pos;
    int          k;
    int          n;
    int          err_before;
    rst_ni       = 1'b0;
    csr_qvalid_i = 1'b0;
    csr_req_i    = '0;
    csr_pready_i = 1'b1;
    $readmemh("gemm_stimulus.txt", stim);
    repeat (4) @(posedge clk_i);
    #DriveDly;
    rst_ni = 1'b1;

    // after reset nothing is requested and the state reads idle
    err_before = errors;
    @(negedge clk_i);
    for (int p = 0; p < Ports; p++) begin
      compare($sformatf("tcdm_req_o[%0d].q_valid", p), 32'(tcdm_req_o[p].q_valid), 32'd0);
    end
    compare("csr_pvalid_o", 32'(csr_pvalid_o), 32'd0);
    @(posedge clk_i);
    #DriveDly;
    csr_access(gemm_cfg_pkg::StateCsr, 1'b1, '0, 5'd9, rdata);
    compare("StateCsr", rdata, 32'd2);
    tests++;
    $display("test %0d reset state: %0d errors", tests, errors - err_before);

    ntests = int'(stim[0]);
    if (ntests < 1) begin
      $display("stimulus file holds no tests");
      errors++;
    end
    pos = 1;
    for (int t = 0; t < ntests; t++) begin
      err_before = errors;
      k = int'(stim[pos]);
      for (int i = 0; i < 6; i++) begin
        cfg[i] = stim[pos + i];
      end
      backpressure = stim[pos + 6][0];
      pos = pos + 7;

      // place A rows and B columns at their strided addresses
      for (int e = 0; e < 4; e++) begin
        exp_c[e] = '0;
      end
      for (int s = 0; s < k; s++) begin
        for (int j = 0; j < 2; j++) begin
          addr = cfg[1] + s * cfg[4] + 4 * j;
          mem[addr[11:2]] = stim[pos + 4 * s + j];
          addr = cfg[2] + s * cfg[5] + 4 * j;
          mem[addr[11:2]] = stim[pos + 4 * s + 2 + j];
        end
        for (int e = 0; e < 4; e++) begin
          exp_c[e] = exp_c[e] + signed_byte_dot(stim[pos + 4 * s + e / 2],
                                                stim[pos + 4 * s + 2 + e % 2]);
        end
      end
      pos = pos + 4 * k;

      for (int i = 0; i < 6; i++) begin
        csr_access(i, 1'b0, cfg[i], 5'd0, rdata);
      end
      for (int i = 0; i < 6; i++) begin
        csr_access(i, 1'b1, '0, 5'(i + 1), rdata);
        compare($sformatf("csr %0d readback", i), rdata, cfg[i]);
      end

      csr_access(gemm_cfg_pkg::StateCsr, 1'b0, 32'd1, 5'd0, rdata);
      if (backpressure) begin
        probe_write_ready(gemm_cfg_pkg::StateCsr, 32'd1, 1'b0);
        probe_write_ready(gemm_cfg_pkg::StrideACsr, cfg[4], 1'b1);
        csr_access(gemm_cfg_pkg::StateCsr, 1'b1, '0, 5'd7, rdata);
        compare("StateCsr", rdata, 32'd1);
      end
      // every read before idle must show busy
      n = 0;
      csr_access(gemm_cfg_pkg::StateCsr, 1'b1, '0, 5'd3, rdata);
      while (rdata !== 32'd2) begin
        compare("StateCsr", rdata, 32'd1);
        n++;
        if (n > Timeout) abort_on_timeout("StateCsr idle");
        csr_access(gemm_cfg_pkg::StateCsr, 1'b1, '0, 5'd3, rdata);
      end

      for (int e = 0; e < 4; e++) begin
        addr = cfg[3] + 4 * e;
        compare($sformatf("C%0d%0d", e / 2, e % 2), mem[addr[11:2]], exp_c[e]);
        compare($sformatf("C%0d%0d vs file", e / 2, e % 2), mem[addr[11:2]], stim[pos + e]);
      end
      pos = pos + 4;

      csr_access(gemm_cfg_pkg::PerfCsr, 1'b1, '0, 5'd4, rdata);
      compare("PerfCsr >= 2K+1", 32'(rdata >= 32'(2 * k + 1)), 32'd1);
      csr_access(gemm_cfg_pkg::StateCsr, 1'b1, '0, 5'd5, rdata);
      compare("StateCsr", rdata, 32'd2);
      tests++;
      $display("test %0d k=%0d backpressure=%0d: %0d errors", tests, k, backpressure,
               errors - err_before);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* gemm_stimulus.txt */
// number of tests, then per test: k ptr_a ptr_b ptr_c stride_a stride_b backpressure,
// per step a0 a1 b0 b1 (four signed bytes each), then expected c00 c01 c10 c11
00000002

// k=1, no back-pressure
00000001 00000100 00000200 00000300 00000010 00000010 00000000
01020304 fffefdfc 01010101 02ff02ff
0000000a 00000002 fffffff6 fffffffe

// k=3, random q_ready and late p_valid
00000003 00000400 00000500 00000600 00000020 00000010 00000001
7f7f7f7f 80808080 01010101 ffffffff
00000005 00000300 00000002 00000700
10203040 f0000000 01000000 00000001
00000216 fffffe44 fffffdf0 00000215

/* snax_gemm_top.f */
gemm_cfg_pkg.sv
tcdm_pkg.sv
gemm_csr.sv
gemm_ctrl.sv
tcdm_req_gen.sv
tcdm_rsp_collect.sv
gemm_mac_array.sv
snax_gemm_top.sv
tb_snax_gemm_chk.sv
tb_snax_gemm.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_snax_gemm \
  -f snax_gemm_top.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
